// File: hw/cpuPkg.sv
`default_nettype none

package cpuPkg;

  // ----------------------------------------------------------------------
  // Widths and basic types
  // ----------------------------------------------------------------------
  localparam int dataWidth = 8;
  localparam int addrWidth = 16;
  localparam int upcWidth  = 6;

  typedef logic [dataWidth-1:0] byte_t;
  typedef logic [addrWidth-1:0] addr_t;
  typedef logic [upcWidth-1:0]  upc_t;

  // Operand codes, low three bits follow the Z80 register field
  typedef enum logic [3:0] {
    selB     = 4'd0,
    selC     = 4'd1,
    selD     = 4'd2,
    selE     = 4'd3,
    selH     = 4'd4,
    selL     = 4'd5,
    selMemHl = 4'd6,
    selA     = 4'd7,
    selPc    = 4'd8,
    selHl    = 4'd9,
    selX8    = 4'd10,
    selX16   = 4'd11,
    selNone  = 4'd15
  } regCode_t;

  typedef enum logic [3:0] {
    nop, setMemAddr, storeRegFromMem, storeX16FromMem, memWrite,
    setPc, jumpInterrupt, z80Op, setIrqEnable, clearIrqEnable
  } microCmd_t;

  typedef struct packed {
    logic      incPc;     // Advance PC at the end of this micro-op
    logic      endOfFlow;
    microCmd_t cmd;
    regCode_t  operand;
  } microOp_t;

  // One opcode byte, read either as a load or as an ALU op
  typedef union packed {
    struct packed {
      logic [1:0] group;
      logic [2:0] dst;
      logic [2:0] src;
    } loadView;
    struct packed {
      logic [4:0] op;
      logic [2:0] src;
    } aluView;
  } opcode_u;

  localparam logic [1:0] groupLoad = 2'b01;
  localparam logic [4:0] aluAnd    = 5'b10100;
  localparam logic [4:0] aluXor    = 5'b10101;

  typedef struct packed {
    logic     enable;
    regCode_t target;
    addr_t    value;
    logic     loadPc;     // PC takes value, wins over increment
  } regWrite_t;

  typedef struct packed {
    addr_t address;
    byte_t writeData;
    logic  writeEnable;
    logic  readRequest;
  } memBus_t;

  // ----------------------------------------------------------------------
  // Flow layout and interrupt vectors
  // ----------------------------------------------------------------------
  localparam upc_t flowInterrupt = 6'd60;
  localparam upc_t romLast       = 6'd61;

  localparam addr_t irqVector [4] = '{16'h0040, 16'h0048, 16'h0050, 16'h0060};

endpackage

`default_nettype wire

// File: hw/microcodeStore.sv
`timescale 1ns/1ps
`default_nettype none

module microcodeStore import cpuPkg::*;
(
  input  wire upc_t   upc,
  input  wire byte_t  opcode,
  output microOp_t    microOp,
  output upc_t        opcodeFlow
);

  // Flow start addresses, per-register flows sit on a stride of three
  localparam upc_t flowNop  = 6'd0;
  localparam upc_t flowLdRn = 6'd1;
  localparam upc_t flowLdHl = 6'd25;
  localparam upc_t flowAlu  = 6'd49;
  localparam upc_t flowJp   = 6'd51;
  localparam upc_t flowEi   = 6'd56;
  localparam upc_t flowDi   = 6'd58;

  localparam byte_t opJp = 8'hC3;
  localparam byte_t opEi = 8'hFB;
  localparam byte_t opDi = 8'hF3;

  // Point the bus back at PC and close the flow
  localparam microOp_t fetchTail = '{1'b0, 1'b1, setMemAddr, selPc};

  microOp_t rom [2**upcWidth];

  // ----------------------------------------------------------------------
  // ROM contents, fields are {incPc, endOfFlow, cmd, operand}
  // ----------------------------------------------------------------------
  always_comb
  begin
    rom = '{default: fetchTail};
    rom[flowNop] = '{1'b1, 1'b1, setMemAddr, selPc};
    for (int r = 0; r < 8; r++)
    begin
      if (r != 6)
      begin
        // LD r,n
        rom[flowLdRn + 3*r]     = '{1'b1, 1'b0, nop, selNone};
        rom[flowLdRn + 3*r + 1] = '{1'b1, 1'b0, storeRegFromMem, regCode_t'(r)};
        // LD (HL),r
        rom[flowLdHl + 3*r]     = '{1'b1, 1'b0, setMemAddr, selHl};
        rom[flowLdHl + 3*r + 1] = '{1'b0, 1'b0, memWrite, regCode_t'(r)};
      end
    end
    rom[flowAlu]       = '{1'b1, 1'b0, z80Op, selNone};   // Opcode still on the bus
    rom[flowJp]        = '{1'b1, 1'b0, nop, selNone};
    rom[flowJp + 1]    = '{1'b1, 1'b0, storeRegFromMem, selX8};
    rom[flowJp + 2]    = '{1'b0, 1'b0, storeX16FromMem, selX16};
    rom[flowJp + 3]    = '{1'b0, 1'b0, setPc, selX16};
    rom[flowEi]        = '{1'b1, 1'b0, setIrqEnable, selNone};
    rom[flowDi]        = '{1'b1, 1'b0, clearIrqEnable, selNone};
    rom[flowInterrupt] = '{1'b0, 1'b0, jumpInterrupt, selNone};
  end

  assign microOp = rom[upc];

  // ----------------------------------------------------------------------
  // Opcode to flow lookup
  // ----------------------------------------------------------------------
  always_comb
  begin
    opcodeFlow = flowNop;  // Anything unlisted runs as NOP
    if (opcode[7:6] == 2'b00 && opcode[2:0] == 3'd6 && opcode[5:3] != 3'd6)
      opcodeFlow = flowLdRn + upc_t'(3 * opcode[5:3]);
    else if (opcode[7:6] == groupLoad && opcode[2:0] != 3'd6)
    begin
      if (opcode[5:3] == 3'd6)
        opcodeFlow = flowLdHl + upc_t'(3 * opcode[2:0]);  // LD (HL),r
      else
        opcodeFlow = flowAlu;                             // LD r,r'
    end
    else if ((opcode[7:3] == aluAnd || opcode[7:3] == aluXor) && opcode[2:0] != 3'd6)
      opcodeFlow = flowAlu;
    else if (opcode == opJp)
      opcodeFlow = flowJp;
    else if (opcode == opEi)
      opcodeFlow = flowEi;
    else if (opcode == opDi)
      opcodeFlow = flowDi;
  end

endmodule

`default_nettype wire

// File: hw/microSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module microSequencer import cpuPkg::*;
(
  input  wire           iClock,
  input  wire           reset,
  input  wire microOp_t microOp,
  input  wire upc_t     opcodeFlow,
  input  wire           pending,
  output upc_t          upc,
  output logic          running
);

  typedef enum logic [1:0] {afterReset, startFlow, runFlow, endFlow} seqState_t;

  seqState_t state;
  seqState_t nextState;

  always_ff @(posedge iClock)
  begin
    if (reset)
      state <= afterReset;
    else
      state <= nextState;
  end

  always_comb
  begin
    case (state)
      afterReset: nextState = startFlow;
      startFlow:  nextState = runFlow;
      runFlow:    nextState = microOp.endOfFlow ? endFlow : runFlow;
      endFlow:    nextState = startFlow;
      default:    nextState = afterReset;
    endcase
  end

  assign running = (state == runFlow);

  // ----------------------------------------------------------------------
  // Micro-program counter
  // ----------------------------------------------------------------------
  always_ff @(posedge iClock)
  begin
    if (reset)
      upc <= '0;
    else if (state == startFlow)
      upc <= pending ? flowInterrupt : opcodeFlow;  // Interrupts only at a boundary
    else if (running && !microOp.endOfFlow)
      upc <= upc + 1'b1;
  end

  // Every flow must close before running off the ROM
  upcInRom: assert property (@(posedge iClock) disable iff (reset) upc <= romLast);

endmodule

`default_nettype wire

// File: hw/interruptControl.sv
`timescale 1ns/1ps
`default_nettype none

module interruptControl import cpuPkg::*;
(
  input  wire       iClock,
  input  wire       reset,
  input  wire [3:0] irqRequest,
  input  wire       setEnable,
  input  wire       clearEnable,
  input  wire       clearLatch,
  output logic      pending,
  output addr_t     vector
);

  logic [3:0] requestLatch;
  logic       irqEnable;

  always_ff @(posedge iClock)
  begin
    if (reset)
    begin
      requestLatch <= '0;
      irqEnable    <= 1'b0;
    end
    else
    begin
      // Requests stick until the handler is entered
      requestLatch <= clearLatch ? '0 : (requestLatch | irqRequest);
      if (setEnable)
        irqEnable <= 1'b1;
      else if (clearEnable)
        irqEnable <= 1'b0;
    end
  end

  assign pending = irqEnable && (requestLatch != '0);

  // Lowest set bit has priority
  always_comb
  begin
    vector = irqVector[0];
    for (int i = 3; i >= 0; i--)
      if (requestLatch[i])
        vector = irqVector[i];
  end

endmodule

`default_nettype wire

// File: hw/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile import cpuPkg::*;
#(
  parameter addr_t resetPc = 16'h0000
)
(
  input  wire            iClock,
  input  wire            reset,
  input  wire regWrite_t regWrite,
  input  wire regCode_t  readSel,
  input  wire regCode_t  addrSel,
  input  wire            addrSelWe,
  input  wire            incPc,
  output addr_t          regData,
  output byte_t          regA,
  output addr_t          memAddress,
  output byte_t          memWriteData
);

  localparam int idxA = 6;

  byte_t    gpr [7];      // B, C, D, E, H, L, then A
  byte_t    x8;
  addr_t    x16;
  addr_t    pc;
  regCode_t addrSelQ;     // Which register drives the address bus
  logic [8:0] writeEn;    // gpr[6:0], X8, X16

  function automatic addr_t pickReg(regCode_t code);
    case (code)
      selB, selC, selD, selE, selH, selL: return addr_t'(gpr[code[2:0]]);
      selA:   return addr_t'(gpr[idxA]);
      selHl:  return {gpr[4], gpr[5]};
      selPc:  return pc;
      selX8:  return addr_t'(x8);
      selX16: return x16;
      default: return '0;
    endcase
  endfunction

  // ----------------------------------------------------------------------
  // Write decode
  // ----------------------------------------------------------------------
  always_comb
  begin
    writeEn = '0;
    if (regWrite.enable)
      case (regWrite.target)
        selB, selC, selD, selE, selH, selL: writeEn[regWrite.target[2:0]] = 1'b1;
        selHl:  writeEn[5:4] = 2'b11;
        selA:   writeEn[idxA] = 1'b1;
        selX8:  writeEn[7] = 1'b1;
        selX16: writeEn[8] = 1'b1;
        default: ;
      endcase
  end

  always_ff @(posedge iClock)
  begin
    if (reset)
      gpr <= '{default: '0};
    else
      for (int i = 0; i < 7; i++)
        if (writeEn[i])
          gpr[i] <= (i == 4 && writeEn[5]) ? regWrite.value[15:8] : regWrite.value[7:0];
  end

  always_ff @(posedge iClock)
  begin
    if (writeEn[7])
      x8 <= regWrite.value[7:0];
    if (writeEn[8])
      x16 <= {regWrite.value[7:0], x8};  // High byte from memory, low from X8
  end

  always_ff @(posedge iClock)
  begin
    if (reset)
    begin
      pc       <= resetPc;
      addrSelQ <= selPc;
    end
    else
    begin
      if (regWrite.loadPc)
        pc <= regWrite.value;
      else if (incPc)
        pc <= pc + 1'b1;
      if (addrSelWe)
        addrSelQ <= addrSel;
    end
  end

  // ----------------------------------------------------------------------
  // Read paths
  // ----------------------------------------------------------------------
  always_comb
  begin
    regData    = pickReg(readSel);
    memAddress = pickReg(addrSelQ);
  end

  assign regA         = gpr[idxA];
  assign memWriteData = regData[7:0];

  // Code 6 means memory, never a register destination
  noMemHlWrite: assert property (@(posedge iClock) disable iff (reset)
    regWrite.enable |-> regWrite.target != selMemHl);

endmodule

`default_nettype wire

// File: hw/microOpExecute.sv
`timescale 1ns/1ps
`default_nettype none

module microOpExecute import cpuPkg::*;
(
  input  wire microOp_t microOp,
  input  wire           running,
  input  wire byte_t    memReadData,
  input  wire addr_t    regData,
  input  wire byte_t    regA,
  input  wire addr_t    vector,
  output regCode_t      readSel,
  output regCode_t      addrSel,
  output logic          addrSelWe,
  output logic          incPc,
  output regWrite_t     regWrite,
  output logic          writeEnable,
  output logic          readRequest,
  output logic          setEnable,
  output logic          clearEnable,
  output logic          clearLatch
);

  opcode_u opcode;
  byte_t   aluResult;

  assign opcode    = memReadData;
  assign aluResult = (opcode.aluView.op == aluXor) ? (regA ^ regData[7:0])
                                                   : (regA & regData[7:0]);

  always_comb
  begin
    readSel     = microOp.operand;
    addrSel     = microOp.operand;
    addrSelWe   = 1'b0;
    incPc       = running & microOp.incPc;
    regWrite    = '{1'b0, microOp.operand, '0, 1'b0};
    writeEnable = 1'b0;
    readRequest = 1'b0;
    setEnable   = 1'b0;
    clearEnable = 1'b0;
    clearLatch  = 1'b0;
    if (running)
      case (microOp.cmd)
        setMemAddr:
        begin
          addrSelWe   = 1'b1;
          readRequest = 1'b1;
        end
        storeRegFromMem:
        begin
          regWrite.enable = 1'b1;
          regWrite.value  = addr_t'(memReadData);
          readRequest     = 1'b1;
        end
        storeX16FromMem:
        begin
          regWrite.enable = 1'b1;
          regWrite.target = selX16;
          regWrite.value  = addr_t'(memReadData);
          readRequest     = 1'b1;
        end
        memWrite: writeEnable = 1'b1;  // Data comes from readSel
        setPc:
        begin
          regWrite.loadPc = 1'b1;
          regWrite.value  = regData;
        end
        jumpInterrupt:
        begin
          regWrite.loadPc = 1'b1;
          regWrite.value  = vector;
          clearLatch      = 1'b1;
          clearEnable     = 1'b1;  // Handler runs with interrupts off
        end
        z80Op:
        begin
          readSel         = regCode_t'({1'b0, opcode.loadView.src});
          regWrite.enable = 1'b1;
          readRequest     = 1'b1;
          if (opcode.loadView.group == groupLoad)
          begin
            regWrite.target = regCode_t'({1'b0, opcode.loadView.dst});
            regWrite.value  = addr_t'(regData[7:0]);
          end
          else
          begin
            regWrite.target = selA;
            regWrite.value  = addr_t'(aluResult);
          end
        end
        setIrqEnable:   setEnable   = 1'b1;
        clearIrqEnable: clearEnable = 1'b1;
        default: ;
      endcase
  end

  // A bus cycle is either a read or a write
  busExclusive: assert final (!(writeEnable && readRequest));

endmodule

`default_nettype wire

// File: hw/cpuCore.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCore import cpuPkg::*;
#(
  parameter addr_t resetPc = 16'h0000
)
(
  input  wire        iClock,
  input  wire        reset,
  input  wire [3:0]  irqRequest,
  input  wire byte_t memReadData,
  output memBus_t    memBus
);

  microOp_t  microOp;
  upc_t      upc;
  upc_t      opcodeFlow;
  logic      running;
  logic      pending;
  addr_t     vector;
  regCode_t  readSel;
  regCode_t  addrSel;
  logic      addrSelWe;
  logic      incPc;
  regWrite_t regWrite;
  addr_t     regData;
  byte_t     regA;
  addr_t     memAddress;
  byte_t     memWriteData;
  logic      writeEnable;
  logic      readRequest;
  logic      setEnable;
  logic      clearEnable;
  logic      clearLatch;

  // ----------------------------------------------------------------------
  // Control path
  // ----------------------------------------------------------------------
  microcodeStore store_i (.upc, .opcode(memReadData), .microOp, .opcodeFlow);

  microSequencer sequencer_i (.iClock, .reset, .microOp, .opcodeFlow, .pending, .upc, .running);

  interruptControl irq_i (.iClock, .reset, .irqRequest, .setEnable, .clearEnable, .clearLatch,
                          .pending, .vector);

  // ----------------------------------------------------------------------
  // Data path
  // ----------------------------------------------------------------------
  microOpExecute execute_i (.microOp, .running, .memReadData, .regData, .regA, .vector, .readSel,
                            .addrSel, .addrSelWe, .incPc, .regWrite, .writeEnable, .readRequest,
                            .setEnable, .clearEnable, .clearLatch);

  registerFile #(.resetPc(resetPc)) regs_i (.iClock, .reset, .regWrite, .readSel, .addrSel,
                                            .addrSelWe, .incPc, .regData, .regA, .memAddress,
                                            .memWriteData);

  assign memBus = '{address:     memAddress,
                    writeData:   memWriteData,
                    writeEnable: writeEnable,
                    readRequest: readRequest};

endmodule

`default_nettype wire

// File: verification/cpuIsaModel.svh
`ifndef CPU_ISA_MODEL_SVH
`define CPU_ISA_MODEL_SVH

// ----------------------------------------------------------------------
// Instruction-level model of the kept subset, run over the image in mem
// ----------------------------------------------------------------------

function automatic void queueWrite(input addr_t address, input byte_t data);
  busWrite_t w;
  w.address = address;
  w.data    = data;
  expected.push_back(w);
endfunction

function automatic void predictWrites(input addr_t startPc, input int maxSteps);
  byte_t      r [8];      // Indexed by the opcode register field, entry 6 unused
  opcode_u    op;
  addr_t      pc;
  addr_t      target;
  logic [3:0] latch;      // Requests seen but not yet served
  logic       irqOn;
  logic       spun;       // The first park loop has been reached
  logic       marked;
  r      = '{default: '0};
  pc     = startPc;
  latch  = '0;
  irqOn  = 1'b0;
  spun   = 1'b0;
  marked = 1'b0;
  for (int step = 0; step < maxSteps; step++)
  begin
    // Interrupts are taken between instructions, lowest bit first
    if (irqOn && latch != '0)
    begin
      for (int i = 3; i >= 0; i--)
        if (latch[i])
          pc = irqVector[i];
      latch = '0;
      irqOn = 1'b0;
    end
    op = mem[pc];
    if (op == 8'hC3)
    begin
      target = {mem[pc + 16'd2], mem[pc + 16'd1]};
      if (target == pc)
      begin
        if (spun)
          return;         // Parked for good
        spun  = 1'b1;
        latch = latch | spinIrq;
      end
      pc = target;
    end
    else
    begin
      if (op == 8'hFB)
        irqOn = 1'b1;
      else if (op == 8'hF3)
        irqOn = 1'b0;
      else if (op.loadView.group == 2'b00 && op.loadView.src == 3'd6 && op.loadView.dst != 3'd6)
      begin
        r[op.loadView.dst] = mem[pc + 16'd1];
        pc = pc + 16'd1;  // Skip the immediate
      end
      else if (op.loadView.group == 2'b01 && op.loadView.src != 3'd6)
      begin
        if (op.loadView.dst != 3'd6)
          r[op.loadView.dst] = r[op.loadView.src];
        else
        begin
          queueWrite({r[4], r[5]}, r[op.loadView.src]);
          if (spun && !marked && r[op.loadView.src] == markerByte)
          begin
            marked = 1'b1;
            latch  = latch | markerIrq;
          end
        end
      end
      else if (op.aluView.src != 3'd6 && op.aluView.op == 5'b10100)
        r[7] = r[7] & r[op.aluView.src];
      else if (op.aluView.src != 3'd6 && op.aluView.op == 5'b10101)
        r[7] = r[7] ^ r[op.aluView.src];
      pc = pc + 16'd1;    // Anything else runs as NOP
    end
  end
endfunction

`endif

// File: verification/cpuCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCoreTb import cpuPkg::*;
();

  typedef struct packed {
    addr_t address;
    byte_t data;
  } busWrite_t;

  localparam int         bodyCount    = 200;
  localparam int         instrBudget  = bodyCount + 40;
  localparam int         drainCycles  = 40;
  localparam addr_t      startAddress = 16'h0100;
  localparam logic [3:0] spinIrq      = 4'b1010;  // Bits 1 and 3 together
  localparam logic [3:0] markerIrq    = 4'b0001;
  localparam byte_t      markerByte   = 8'hA5;    // Written by the 0x48 handler

  logic        iClock;
  logic        reset;
  logic [3:0]  irqRequest;
  byte_t       memReadData;
  memBus_t     memBus;
  byte_t       mem [65536];
  busWrite_t   expected [$];
  int          total;
  int          seen;
  addr_t       emitAt;
  addr_t       spinAt;
  logic [31:0] seed;

  `include "cpuIsaModel.svh"

  cpuCore #(.resetPc(startAddress)) dut_i (.iClock, .reset, .irqRequest, .memReadData, .memBus);

  initial
  begin
    iClock = 1'b0;
    forever #20 iClock = ~iClock;
  end

  // Zero-wait memory, asynchronous read
  assign memReadData = mem[memBus.address];

  always @(posedge iClock)
    if (memBus.writeEnable)
      mem[memBus.address] <= memBus.writeData;

  function automatic int randomBelow(input int n);
    seed = seed * 32'd1664525 + 32'd1013904223;  // LCG
    return int'((seed >> 16) % n);
  endfunction

  task automatic emitByte(input byte_t b);
    mem[emitAt] = b;
    emitAt = emitAt + 16'd1;
  endtask

  task automatic placeCode(input addr_t at, input logic [95:0] code, input int count);
    emitAt = at;
    for (int i = count - 1; i >= 0; i--)
      emitByte(code[8*i +: 8]);
  endtask

  task automatic checkValue(input string what, input logic [15:0] got, input logic [15:0] want);
    if (got !== want)
    begin
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, want);
      $display("Simulation failed");
      $fatal(1, "Check failed on %s", what);
    end
  endtask

  // ----------------------------------------------------------------------
  // Program: random body, then the interrupt handlers
  // ----------------------------------------------------------------------
  task automatic buildProgram();
    logic [2:0] dst;
    logic [2:0] src;
    addr_t      target;
    for (int a = 0; a < 65536; a++)
      mem[a] = 8'h00;                           // Empty memory reads as NOP
    placeCode(startAddress, {8'h26, 8'hC0, 8'h2E, byte_t'(randomBelow(256))}, 4);
    for (int i = 0; i < bodyCount; i++)
    begin
      dst = 3'(randomBelow(5));                 // B..E or A, HL stays put
      if (dst == 3'd4)
        dst = 3'd7;
      src = 3'(randomBelow(7));
      if (src == 3'd6)
        src = 3'd7;
      case (randomBelow(8))
        0: placeCode(emitAt, {2'b00, dst, 3'd6, byte_t'(randomBelow(256))}, 2);
        1: emitByte({2'b01, dst, src});
        2: emitByte({5'b10100, src});
        3: emitByte({5'b10101, src});
        4:
        begin
          target = emitAt + 16'd4;              // Hop over one store
          placeCode(emitAt, {8'hC3, target[7:0], target[15:8], 8'h77}, 4);
        end
        default: emitByte({5'b01110, src});
      endcase
    end
    placeCode(emitAt, 16'h77FB, 2);             // Expose A, then EI
    spinAt = emitAt;
    placeCode(emitAt, {8'hC3, spinAt[7:0], spinAt[15:8]}, 3);
    placeCode(16'h0040, 48'h3E3C77C34300, 6);
    placeCode(16'h0048, 56'h003EA577C30020, 7);
    placeCode(16'h0050, 48'h3EEE77C35300, 6);   // Wrong vectors leave 0xEE
    placeCode(16'h0060, 48'h3EEE77C36300, 6);
    placeCode(16'h2000, 72'hF3003EB677FBC30620, 9);
  endtask

  // Interrupt requests, each cued by what the core has just done
  initial
  begin
    addr_t lastAddress;
    irqRequest  = '0;
    lastAddress = '0;
    wait (reset === 1'b0);
    do
    begin
      lastAddress = memBus.address;
      @(negedge iClock);
    end
    while (!(lastAddress == spinAt + 16'd2 && memBus.address == spinAt));
    @(posedge iClock);
    irqRequest <= spinIrq;
    @(posedge iClock);
    irqRequest <= '0;
    do
      @(negedge iClock);
    while (!(memBus.writeEnable && memBus.writeData == markerByte));
    @(posedge iClock);
    irqRequest <= markerIrq;                    // Must wait for the next EI
    @(posedge iClock);
    irqRequest <= '0;
  end

  always @(negedge iClock)
  begin
    busWrite_t want;
    if (reset === 1'b0 && memBus.writeEnable === 1'b1)
    begin
      if (expected.size() == 0)
      begin
        $display("Unexpected extra memory write to address %h", memBus.address);
        $display("Simulation failed");
        $fatal(1, "Write beyond the predicted sequence");
      end
      else
      begin
        want = expected.pop_front();
        checkValue("write address", memBus.address, want.address);
        checkValue("write data", memBus.writeData, want.data);
        seen++;
      end
    end
  end

  initial
  begin
    reset = 1'b1;
    seed  = 32'hc8fc;
    seen  = 0;
    buildProgram();
    predictWrites(startAddress, instrBudget * 4);
    total = expected.size();
    repeat (5) @(posedge iClock);
    reset <= 1'b0;
    @(negedge iClock);
    checkValue("address after reset", memBus.address, startAddress);
    checkValue("read request after reset", memBus.readRequest, 16'd0);
    checkValue("write enable after reset", memBus.writeEnable, 16'd0);
    wait (seen == total);
    repeat (drainCycles) @(negedge iClock);     // Room for a stray late write
    if (expected.size() == 0 && seen == total)
    begin
      $display("Simulation passed");
      $finish;
    end
    else
    begin
      $display("Simulation failed");
      $fatal(1, "Predicted writes were left over");
    end
  end

  initial
  begin
    #((instrBudget * 12 + 5 + drainCycles) * 40);
    $display("Timeout: the core did not produce all predicted writes in time");
    $display("Simulation failed");
    $fatal(1, "Watchdog expired");
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+verification
hw/cpuPkg.sv
hw/microcodeStore.sv
hw/microSequencer.sv
hw/interruptControl.sv
hw/registerFile.sv
hw/microOpExecute.sv
hw/cpuCore.sv
verification/cpuCoreTb.sv
